// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the instruction cache testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module icache_tb -f icache.f \
		-Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim

clean:
	rm -rf obj_dir

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import icache_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    hold_ar,
	input  logic    hold_r,
	input  logic    ar_valid,
	output logic    ar_ready,
	input  axi_ar_t ar,
	output logic    r_valid,
	input  logic    r_ready,
	output axi_r_t  r
);

	logic       busy;
	addr_t      beat_addr;
	logic [7:0] beats_left;
	logic       beat_done;

	// contents follow the byte address, no storage needed
	function automatic logic [31:0] word_at(input addr_t a);
		return ((a << 7) | (a >> 25)) ^ 32'hc0de_1234;
	endfunction

	// one burst at a time
	assign ar_ready  = !busy && !hold_ar;
	assign beat_done = r_valid && r_ready;
	assign r.rdata   = word_at(beat_addr);
	assign r.rlast   = (beats_left == 8'd0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy       <= 1'b0;
			r_valid    <= 1'b0;
			beat_addr  <= '0;
			beats_left <= '0;
		end else begin
			if (ar_valid && ar_ready) begin
				busy       <= 1'b1;
				beat_addr  <= ar.araddr;
				beats_left <= ar.arlen;
			end else if (beat_done) begin
				beat_addr  <= beat_addr + AXI_BEAT_BYTES;
				beats_left <= beats_left - 8'd1;
				if (r.rlast) begin
					busy <= 1'b0;
				end
			end
			// a raised rvalid stays up until taken
			if (!r_valid || beat_done) begin
				r_valid <= busy && !hold_r && !(beat_done && r.rlast);
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

	localparam int DATA_WIDTH     = 64;
	localparam int LINE_WIDTH     = 256;
	localparam int SET_ASSOC      = 4;
	localparam int CACHE_SIZE     = 4096;
	localparam int LINE_BYTES     = LINE_WIDTH / 8;
	localparam int LINE_OFFSET    = $clog2(LINE_BYTES);
	localparam int SETS           = CACHE_SIZE / LINE_WIDTH / SET_ASSOC;
	localparam int INDEX_WIDTH    = $clog2(SETS);
	localparam int MAX_FETCHES    = 400;
	localparam int TIMEOUT_CYCLES = MAX_FETCHES * 40;

	typedef struct packed {
		addr_t       addr;
		logic        must_hit;
		logic        timed;
		logic [31:0] cycle;
	} pending_t;

	logic                  clk;
	logic                  rst;
	logic                  req_valid;
	logic                  req_ready;
	fetch_req_t            req;
	logic                  resp_valid;
	logic                  resp_ready;
	logic [DATA_WIDTH-1:0] resp_data;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_ar_t               ar;
	logic                  r_valid;
	logic                  r_ready;
	axi_r_t                r;
	logic                  hold_ar;
	logic                  hold_r;

	logic [31:0]           lfsr_state = 32'd76626;
	logic [31:0]           cycles = '0;
	logic                  timing_phase;
	logic                  was_stalled = 1'b0;
	logic                  burst_open = 1'b0;
	logic [DATA_WIDTH-1:0] held_data;
	pending_t              pend_q[$];
	addr_t                 last_line [SETS];
	logic                  last_valid [SETS];
	bit                    line_seen [addr_t];
	int                    ar_total = 0;

	// fibonacci form with taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic logic [31:0] mem_word(input addr_t a);
		return {a[24:0], a[31:25]} ^ 32'hc0de_1234;
	endfunction

	function automatic logic [63:0] expected_fetch(input addr_t a);
		return {mem_word(a + 32'd4), mem_word(a)};
	endfunction

	function automatic addr_t line_of(input addr_t a);
		return a & ~addr_t'(LINE_BYTES - 1);
	endfunction

	// 8-byte aligned address inside a small window
	function automatic addr_t pick_addr(input addr_t base, input int span_log2);
		return base + (rand_bits(span_log2) << 3);
	endfunction

	task automatic report_failure();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			report_failure();
		end
	endtask

	task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic issue(input addr_t a);
		req_valid = 1'b1;
		req.addr  = a;
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic drain();
		req_valid = 1'b0;
		while (pend_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	icache_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.LINE_WIDTH (LINE_WIDTH),
		.SET_ASSOC  (SET_ASSOC),
		.CACHE_SIZE (CACHE_SIZE)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_data  (resp_data),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar         (ar),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.r          (r)
	);

	axi_mem_model u_mem (
		.clk      (clk),
		.rst      (rst),
		.hold_ar  (hold_ar),
		.hold_r   (hold_r),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar       (ar),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.r        (r)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// response stalls and memory gaps
	initial begin
		@(negedge rst);
		forever begin
			@(posedge clk);
			#1;
			resp_ready = timing_phase || (rand_bits(2) != 32'd0);
			hold_ar    = next_bit();
			hold_r     = (rand_bits(2) == 32'd0);
		end
	end

	// scoreboard on pre-edge values
	always @(posedge clk) begin
		pending_t               ent;
		logic [INDEX_WIDTH-1:0] idx;
		if (!rst) begin
			cycles = cycles + 32'd1;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout: responses stopped arriving");
				report_failure();
			end
			if (was_stalled) begin
				expect_true(resp_valid, "resp_valid dropped before it was accepted");
				expect_eq("resp_data", held_data, resp_data);
			end
			if (resp_valid && !resp_ready) begin
				expect_true(!req_ready, "req_ready high while the response is stalled");
			end
			was_stalled = resp_valid && !resp_ready;
			held_data   = resp_data;
			// beats are taken only between the address and the last beat
			expect_eq("r_ready", 64'(burst_open), 64'(r_ready));
			if (ar_valid && ar_ready) begin
				expect_true(pend_q.size() != 0, "refill requested with no fetch outstanding");
				ent = pend_q[0];
				expect_eq("araddr", 64'(line_of(ent.addr)), 64'(ar.araddr));
				expect_eq("arlen", 64'(7), 64'(ar.arlen));
				expect_eq("arsize", 64'(2), 64'(ar.arsize));
				expect_eq("arburst", 64'(burst_incr), 64'(ar.arburst));
				expect_true(!ent.must_hit, "refill requested for a line that should be cached");
				ar_total++;
				burst_open = 1'b1;
			end
			if (r_valid && r_ready && r.rlast) begin
				burst_open = 1'b0;
			end
			if (resp_valid && resp_ready) begin
				expect_true(pend_q.size() != 0, "response with no fetch outstanding");
				ent = pend_q.pop_front();
				expect_eq("resp_data", expected_fetch(ent.addr), resp_data);
				if (ent.timed) begin
					expect_true(cycles == ent.cycle + 32'd1, "hit response not on the next edge");
				end
			end
			if (timing_phase && req_valid) begin
				expect_true(req_ready, "hit stream stalled on the request side");
			end
			if (req_valid && req_ready) begin
				idx          = req.addr[LINE_OFFSET +: INDEX_WIDTH];
				ent.addr     = req.addr;
				ent.must_hit = last_valid[idx] && (last_line[idx] == line_of(req.addr));
				ent.timed    = timing_phase;
				ent.cycle    = cycles;
				pend_q.push_back(ent);
				last_valid[idx] = 1'b1;
				last_line[idx]  = line_of(req.addr);
				line_seen[line_of(req.addr)] = 1'b1;
			end
		end
	end

	initial begin
		rst          = 1'b1;
		req_valid    = 1'b0;
		req          = '0;
		resp_ready   = 1'b0;
		hold_ar      = 1'b0;
		hold_r       = 1'b0;
		timing_phase = 1'b0;
		for (int i = 0; i < SETS; i++) begin
			last_valid[i] = 1'b0;
			last_line[i]  = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// cold misses and reuse in a 1 KB window
		for (int i = 0; i < 60; i++) begin
			issue(pick_addr(32'h0001_0000, 7));
		end
		drain();

		// six lines on set 1 against four ways
		for (int round = 0; round < 5; round++) begin
			for (int k = 0; k < 6; k++) begin
				issue(32'h4000_0020 + 32'(k * LINE_BYTES * SETS) + 32'((round % 2) * 16));
				issue(32'h4000_0028 + 32'(k * LINE_BYTES * SETS) + 32'((round % 2) * 16));
			end
		end
		drain();

		// warm one line per set and then stream hits
		for (int k = 0; k < SETS; k++) begin
			issue(32'h2000_0000 + 32'(k * LINE_BYTES));
		end
		drain();
		timing_phase = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		for (int i = 0; i < 48; i++) begin
			issue(pick_addr(32'h2000_0000, 4));
		end
		drain();
		timing_phase = 1'b0;

		// mixed traffic with request gaps
		for (int i = 0; i < 200; i++) begin
			if (rand_bits(2) == 32'd0) begin
				req_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			issue(pick_addr(next_bit() ? 32'h0001_0000 : 32'h4000_0000, 7));
		end
		drain();

		if (ar_total > line_seen.size()) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("refill count shows no evictions");
			report_failure();
		end
	end

endmodule

`default_nettype wire

// ==== icache.f ====
logic/icache_pkg.sv
logic/icache_ram.sv
logic/replace_lfsr.sv
logic/fetch_stage.sv
logic/icache_lookup.sv
logic/refill_unit.sv
logic/icache_top.sv
dv/axi_mem_model.sv
dv/icache_tb.sv

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import icache_pkg::*; #(
	parameter int LINE_WIDTH   = 256,
	parameter int SET_ASSOC    = 4,
	parameter int CACHE_SIZE   = 4096,
	localparam int INDEX_WIDTH = $clog2(CACHE_SIZE / LINE_WIDTH / SET_ASSOC)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  fetch_req_t             req,
	input  logic                   advance,
	output logic                   rd_en,
	output logic [INDEX_WIDTH-1:0] rd_index,
	output logic                   s2_valid,
	output addr_t                  s2_addr
);

	localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);

	logic armed;

	// ready only once out of reset
	assign req_ready = armed & advance;
	assign rd_en     = req_valid & req_ready;
	assign rd_index  = req.addr[LINE_OFFSET +: INDEX_WIDTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			armed    <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (advance) begin
				s2_valid <= rd_en;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			s2_addr <= req.addr;
		end
	end

endmodule

`default_nettype wire

// ==== logic/icache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lookup import icache_pkg::*; #(
	parameter int DATA_WIDTH   = 64,
	parameter int LINE_WIDTH   = 256,
	parameter int SET_ASSOC    = 4,
	parameter int CACHE_SIZE   = 4096,
	localparam int INDEX_WIDTH = $clog2(CACHE_SIZE / LINE_WIDTH / SET_ASSOC),
	localparam int WAY_BITS    = $clog2(SET_ASSOC)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_en,
	input  logic [INDEX_WIDTH-1:0] rd_index,
	input  logic                   s2_valid,
	input  addr_t                  s2_addr,
	output logic                   advance,
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output logic [DATA_WIDTH-1:0]  resp_data,
	output logic                   miss_valid,
	output addr_t                  miss_addr,
	input  logic [WAY_BITS-1:0]    victim,
	input  logic                   fill_valid,
	input  logic [LINE_WIDTH-1:0]  fill_line
);

	localparam int SETS        = CACHE_SIZE / LINE_WIDTH / SET_ASSOC;
	localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);
	localparam int WORD_OFFSET = $clog2(DATA_WIDTH / 8);
	localparam int WORDS       = LINE_WIDTH / DATA_WIDTH;
	localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	typedef logic [WORDS-1:0][DATA_WIDTH-1:0] line_t;

	tag_entry_t [SET_ASSOC-1:0] tag_rdata;
	tag_entry_t                 tag_wdata;
	line_t [SET_ASSOC-1:0]      data_rdata;
	logic [SET_ASSOC-1:0]       way_we;
	logic [SET_ASSOC-1:0]       hit;
	logic [INDEX_WIDTH-1:0]     ram_index;
	logic [INDEX_WIDTH-1:0]     s2_index;
	logic [TAG_WIDTH-1:0]       s2_tag;
	logic [$clog2(WORDS)-1:0]   s2_word;
	logic                       replay;

	assign s2_index = s2_addr[LINE_OFFSET +: INDEX_WIDTH];
	assign s2_tag   = s2_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign s2_word  = s2_addr[WORD_OFFSET +: $clog2(WORDS)];

	// held index keeps the outputs stable and re-reads after a fill
	assign ram_index = rd_en ? rd_index : s2_index;

	assign tag_wdata.valid = 1'b1;
	assign tag_wdata.tag   = s2_tag;

	always_comb begin
		for (int i = 0; i < SET_ASSOC; i++) begin
			way_we[i] = fill_valid && (victim == WAY_BITS'(i));
			hit[i]    = tag_rdata[i].valid && (tag_rdata[i].tag == s2_tag);
		end
	end

	always_comb begin
		resp_data = '0;
		for (int i = 0; i < SET_ASSOC; i++) begin
			resp_data |= {DATA_WIDTH{hit[i]}} & data_rdata[i][s2_word];
		end
	end

	assign resp_valid = s2_valid && (|hit);
	assign advance    = !s2_valid || (resp_valid && resp_ready);
	// RAM outputs are still stale in the cycle after the fill
	assign miss_valid = s2_valid && !(|hit) && !replay;
	assign miss_addr  = s2_addr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			replay <= 1'b0;
		end else begin
			replay <= fill_valid;
		end
	end

	for (genvar i = 0; i < SET_ASSOC; i++) begin : gen_way
		icache_ram #(
			.DEPTH (SETS),
			.WIDTH ($bits(tag_entry_t))
		) u_tag (
			.clk  (clk),
			.rst  (rst),
			.we   (way_we[i]),
			.addr (ram_index),
			.din  (tag_wdata),
			.dout (tag_rdata[i])
		);

		icache_ram #(
			.DEPTH (SETS),
			.WIDTH (LINE_WIDTH)
		) u_data (
			.clk  (clk),
			.rst  (rst),
			.we   (way_we[i]),
			.addr (ram_index),
			.din  (fill_line),
			.dout (data_rdata[i])
		);
	end

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	localparam int ADDR_WIDTH     = 32;
	localparam int AXI_BEAT_BYTES = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;

	typedef struct packed {
		addr_t addr;
	} fetch_req_t;

	// AXI burst type encodings
	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01,
		burst_wrap  = 2'b10
	} axi_burst_t;

	typedef struct packed {
		addr_t      araddr;
		logic [7:0] arlen;
		logic [2:0] arsize;
		axi_burst_t arburst;
	} axi_ar_t;

	typedef struct packed {
		logic [AXI_BEAT_BYTES*8-1:0] rdata;
		logic                        rlast;
	} axi_r_t;

	typedef enum logic [1:0] {
		refill_idle,
		refill_addr,
		refill_recv
	} refill_state_t;

endpackage

`default_nettype wire

// ==== logic/icache_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         din,
	output logic [WIDTH-1:0]         dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	// old contents come out on a write to the same entry
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			dout <= '0;
		end else begin
			if (we) begin
				mem[addr] <= din;
			end
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
	parameter int DATA_WIDTH = 64,
	parameter int LINE_WIDTH = 256,
	parameter int SET_ASSOC  = 4,
	parameter int CACHE_SIZE = 4096
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  fetch_req_t            req,
	output logic                  resp_valid,
	input  logic                  resp_ready,
	output logic [DATA_WIDTH-1:0] resp_data,
	output logic                  ar_valid,
	input  logic                  ar_ready,
	output axi_ar_t               ar,
	input  logic                  r_valid,
	output logic                  r_ready,
	input  axi_r_t                r
);

	localparam int INDEX_WIDTH = $clog2(CACHE_SIZE / LINE_WIDTH / SET_ASSOC);
	localparam int WAY_BITS    = $clog2(SET_ASSOC);

	logic                   advance;
	logic                   rd_en;
	logic [INDEX_WIDTH-1:0] rd_index;
	logic                   s2_valid;
	addr_t                  s2_addr;
	logic                   miss_valid;
	addr_t                  miss_addr;
	logic [WAY_BITS-1:0]    victim;
	logic                   fill_valid;
	logic [LINE_WIDTH-1:0]  fill_line;

	fetch_stage #(
		.LINE_WIDTH (LINE_WIDTH),
		.SET_ASSOC  (SET_ASSOC),
		.CACHE_SIZE (CACHE_SIZE)
	) u_fetch (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.advance   (advance),
		.rd_en     (rd_en),
		.rd_index  (rd_index),
		.s2_valid  (s2_valid),
		.s2_addr   (s2_addr)
	);

	icache_lookup #(
		.DATA_WIDTH (DATA_WIDTH),
		.LINE_WIDTH (LINE_WIDTH),
		.SET_ASSOC  (SET_ASSOC),
		.CACHE_SIZE (CACHE_SIZE)
	) u_lookup (
		.clk        (clk),
		.rst        (rst),
		.rd_en      (rd_en),
		.rd_index   (rd_index),
		.s2_valid   (s2_valid),
		.s2_addr    (s2_addr),
		.advance    (advance),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_data  (resp_data),
		.miss_valid (miss_valid),
		.miss_addr  (miss_addr),
		.victim     (victim),
		.fill_valid (fill_valid),
		.fill_line  (fill_line)
	);

	refill_unit #(
		.LINE_WIDTH (LINE_WIDTH),
		.SET_ASSOC  (SET_ASSOC)
	) u_refill (
		.clk        (clk),
		.rst        (rst),
		.miss_valid (miss_valid),
		.miss_addr  (miss_addr),
		.victim     (victim),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar         (ar),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.r          (r),
		.fill_valid (fill_valid),
		.fill_line  (fill_line)
	);

endmodule

`default_nettype wire

// ==== logic/refill_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_unit import icache_pkg::*; #(
	parameter int LINE_WIDTH = 256,
	parameter int SET_ASSOC  = 4,
	localparam int WAY_BITS  = $clog2(SET_ASSOC)
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  miss_valid,
	input  addr_t                 miss_addr,
	output logic [WAY_BITS-1:0]   victim,
	output logic                  ar_valid,
	input  logic                  ar_ready,
	output axi_ar_t               ar,
	input  logic                  r_valid,
	output logic                  r_ready,
	input  axi_r_t                r,
	output logic                  fill_valid,
	output logic [LINE_WIDTH-1:0] fill_line
);

	localparam int BEAT_BITS   = AXI_BEAT_BYTES * 8;
	localparam int BEATS       = LINE_WIDTH / BEAT_BITS;
	localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);
	localparam int BUF_WIDTH   = LINE_WIDTH - BEAT_BITS;

	refill_state_t        state;
	refill_state_t        state_next;
	logic                 lfsr_update;
	logic [31:0]          lfsr_val;
	addr_t                line_addr;
	logic [BUF_WIDTH-1:0] beat_buf;
	logic                 beat_take;

	replace_lfsr u_lfsr (
		.clk    (clk),
		.rst    (rst),
		.update (lfsr_update),
		.val    (lfsr_val)
	);

	assign ar.araddr  = line_addr;
	assign ar.arlen   = 8'(BEATS - 1);
	assign ar.arsize  = 3'($clog2(AXI_BEAT_BYTES));
	assign ar.arburst = burst_incr;

	assign ar_valid    = (state == refill_addr);
	assign r_ready     = (state == refill_recv);
	assign beat_take   = r_valid && r_ready;
	assign lfsr_update = (state == refill_idle) && miss_valid;

	// last beat goes straight into the line, no extra cycle
	assign fill_valid = beat_take && r.rlast;
	assign fill_line  = {r.rdata, beat_buf};

	always_comb begin
		state_next = state;
		unique case (state)
			refill_idle: begin
				if (miss_valid) begin
					state_next = refill_addr;
				end
			end
			refill_addr: begin
				if (ar_ready) begin
					state_next = refill_recv;
				end
			end
			refill_recv: begin
				if (fill_valid) begin
					state_next = refill_idle;
				end
			end
			default: begin
				state_next = refill_idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= refill_idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (lfsr_update) begin
			line_addr <= {miss_addr[ADDR_WIDTH-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}};
			victim    <= lfsr_val[WAY_BITS-1:0];
		end
		// first beat ends up in the low word
		if (beat_take) begin
			beat_buf <= {r.rdata, beat_buf[BUF_WIDTH-1:BEAT_BITS]};
		end
	end

endmodule

`default_nettype wire

// ==== logic/replace_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module replace_lfsr (
	input  logic        clk,
	input  logic        rst,
	input  logic        update,
	output logic [31:0] val
);

	localparam logic [31:0] SEED = 32'h5eed_c0de;
	// x^32 + x^22 + x^2 + x + 1, right shifting form
	localparam logic [31:0] TAPS = 32'h8020_0003;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			val <= SEED;
		end else if (update) begin
			val <= {1'b0, val[31:1]} ^ (val[0] ? TAPS : 32'h0);
		end
	end

endmodule

`default_nettype wire
